// ==== Bender.yml ====
package:
  name: lc3b_core

sources:
  - files:
      - design/lc3b_pkg.sv
      - design/control_rom.sv
      - design/regfile.sv
      - design/execute_unit.sv
      - design/stall_logic.sv
      - design/datapath.sv
      - design/lc3b_core.sv
  - target: simulation
    files:
      - testbench/tb_memory.sv
      - testbench/tb_lc3b_core.sv

// ==== design/control_rom.sv ====
module control_rom
(
	input lc3b_pkg::lc3b_word ir,
	output lc3b_pkg::lc3b_control control
);

	always_comb
	begin
		control = '0;
		// raw opcode kept so unknown encodings never match a kept one
		control.opcode = lc3b_pkg::lc3b_opcode'(ir[15:12]);
		case (control.opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and:
			begin
				control.alu_op = (control.opcode == lc3b_pkg::op_add) ?
					lc3b_pkg::alu_add : lc3b_pkg::alu_and;
				control.sr2_is_imm = ir[5];
				control.load_regfile = 1'b1;
				control.load_cc = 1'b1;
				control.wb_sel = lc3b_pkg::wb_alu;
			end
			lc3b_pkg::op_not:
			begin
				// only the xor-with-all-ones form
				if (ir[5] && ir[4])
				begin
					control.alu_op = lc3b_pkg::alu_not;
					control.load_regfile = 1'b1;
					control.load_cc = 1'b1;
				end
			end
			lc3b_pkg::op_br:
			begin
				control.addr_offset_sel = 1'b1;
				control.addr_base_pc = 1'b1;
			end
			lc3b_pkg::op_lea:
			begin
				control.addr_offset_sel = 1'b1;
				control.addr_base_pc = 1'b1;
				control.load_regfile = 1'b1;
				control.wb_sel = lc3b_pkg::wb_addr;
			end
			lc3b_pkg::op_ldr, lc3b_pkg::op_ldb, lc3b_pkg::op_ldi:
			begin
				control.read_memory = 1'b1;
				control.byte_op = (control.opcode == lc3b_pkg::op_ldb);
				control.indirect = (control.opcode == lc3b_pkg::op_ldi);
				control.load_regfile = 1'b1;
				control.load_cc = 1'b1;
				control.wb_sel = lc3b_pkg::wb_mem;
			end
			lc3b_pkg::op_str, lc3b_pkg::op_stb, lc3b_pkg::op_sti:
			begin
				// store data rides through the alu
				control.sr2_from_dest = 1'b1;
				control.alu_op = lc3b_pkg::alu_pass;
				control.write_memory = 1'b1;
				control.byte_op = (control.opcode == lc3b_pkg::op_stb);
				control.indirect = (control.opcode == lc3b_pkg::op_sti);
			end
			default:
			begin
				// unsupported, stays a nop
				control.load_regfile = 1'b0;
			end
		endcase
	end

endmodule : control_rom

// ==== design/datapath.sv ====
module datapath
(
	input logic clk,
	input logic arst_n,
	input logic mem_resp_a,
	input lc3b_pkg::lc3b_word mem_rdata_a,
	output logic mem_read_a,
	output lc3b_pkg::lc3b_word mem_address_a,
	input logic mem_resp_b,
	input lc3b_pkg::lc3b_word mem_rdata_b,
	output logic mem_read_b,
	output logic mem_write_b,
	output lc3b_pkg::lc3b_word mem_address_b,
	output lc3b_pkg::lc3b_word mem_wdata_b,
	output logic [1:0] mem_wmask_b,
	output lc3b_pkg::lc3b_word de_ir,
	input lc3b_pkg::lc3b_control de_control,
	output lc3b_pkg::lc3b_reg src_a,
	output lc3b_pkg::lc3b_reg src_b,
	input lc3b_pkg::lc3b_word reg_a,
	input lc3b_pkg::lc3b_word reg_b,
	output logic wb_load_reg,
	output lc3b_pkg::lc3b_reg wb_dest,
	output lc3b_pkg::lc3b_word wb_data
);

	lc3b_pkg::lc3b_word pc, pc_plus2, ibuf, fetch_word, de_next_pc;
	lc3b_pkg::lc3b_word ex_alu_out, ex_address, mdr, rdata_live, load_value;
	lc3b_pkg::de_ex_t de_ex;
	lc3b_pkg::ex_mem_t ex_mem;
	lc3b_pkg::mem_wb_t mem_wb;
	lc3b_pkg::lc3b_nzp nzp, wb_cc;
	logic fetch_held, de_valid, advance, flush, mem_rd, mem_wr, first_phase;
	logic use_pointer, hold_first, access_done, strobe_mask, wb_load_cc;

	////////////////////
	// fetch
	////////////////////
	assign pc_plus2 = pc + 16'd2;
	assign mem_address_a = pc;
	assign fetch_word = fetch_held ? ibuf : mem_rdata_a;

	// one step for every stage, when fetch and data port are both done
	assign advance = (mem_resp_a || fetch_held) && (!(mem_rd || mem_wr) || access_done);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pc <= lc3b_pkg::reset_pc;
			mem_read_a <= 1'b0;
			fetch_held <= 1'b0;
		end
		else if (advance)
		begin
			pc <= flush ? mem_wb.address : pc_plus2;
			mem_read_a <= 1'b1;
			fetch_held <= 1'b0;
		end
		else if (mem_resp_a)
		begin
			// park the word until the data side catches up
			mem_read_a <= 1'b0;
			fetch_held <= 1'b1;
		end
		else
			mem_read_a <= !fetch_held;
	end

	always_ff @(posedge clk)
	begin
		if (mem_resp_a && !advance)
			ibuf <= mem_rdata_a;
	end

	////////////////////
	// pipeline registers
	////////////////////
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			de_valid <= 1'b0;
			de_ir <= lc3b_pkg::nop_word;
			de_next_pc <= lc3b_pkg::reset_pc;
			de_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end
		else if (advance)
		begin
			// a taken branch squashes everything younger
			de_valid <= !flush;
			de_ir <= fetch_word;
			de_next_pc <= pc_plus2;

			de_ex.valid <= de_valid && !flush;
			de_ex.control <= de_control;
			de_ex.ir <= de_ir;
			de_ex.next_pc <= de_next_pc;
			de_ex.sr1 <= reg_a;
			de_ex.sr2 <= reg_b;

			ex_mem.valid <= de_ex.valid && !flush;
			ex_mem.control <= de_ex.control;
			ex_mem.ir <= de_ex.ir;
			ex_mem.next_pc <= de_ex.next_pc;
			ex_mem.alu_out <= ex_alu_out;
			ex_mem.address <= ex_address;

			mem_wb.valid <= ex_mem.valid && !flush;
			mem_wb.control <= ex_mem.control;
			mem_wb.ir <= ex_mem.ir;
			mem_wb.next_pc <= ex_mem.next_pc;
			mem_wb.alu_out <= ex_mem.alu_out;
			mem_wb.address <= ex_mem.address;
			mem_wb.rdata <= load_value;
		end
	end

	// decode
	assign src_a = de_ir[8:6];
	assign src_b = de_control.sr2_from_dest ? de_ir[11:9] : de_ir[2:0];

	execute_unit execute_unit
	(
		.control(de_ex.control),
		.next_pc(de_ex.next_pc),
		.ir(de_ex.ir),
		.sr1(de_ex.sr1),
		.sr2(de_ex.sr2),
		.alu_out(ex_alu_out),
		.address(ex_address)
	);

	////////////////////
	// memory
	////////////////////
	assign mem_rd = ex_mem.valid && !flush && ex_mem.control.read_memory;
	assign mem_wr = ex_mem.valid && !flush && ex_mem.control.write_memory;

	stall_logic stall_logic
	(
		.clk,
		.arst_n,
		.advance,
		.read(mem_rd),
		.write(mem_wr),
		.indirect(ex_mem.control.indirect),
		.resp(mem_resp_b),
		.use_pointer,
		.hold_first,
		.access_done,
		.strobe_mask
	);

	// first half of ldi/sti always reads the pointer
	assign first_phase = ex_mem.control.indirect && !use_pointer;
	assign mem_read_b = strobe_mask && (mem_rd || (mem_wr && first_phase));
	assign mem_write_b = strobe_mask && mem_wr && !first_phase;
	assign mem_address_b = use_pointer ? mdr : ex_mem.address;

	// stb puts the byte on both lanes and masks one
	assign mem_wdata_b = ex_mem.control.byte_op ?
		{ex_mem.alu_out[7:0], ex_mem.alu_out[7:0]} : ex_mem.alu_out;
	assign mem_wmask_b = !ex_mem.control.byte_op ? 2'b11 :
		(mem_address_b[0] ? 2'b10 : 2'b01);

	always_ff @(posedge clk)
	begin
		if (hold_first)
			mdr <= mem_rdata_b;
	end

	assign rdata_live = mem_resp_b ? mem_rdata_b : mdr;
	assign load_value = !ex_mem.control.byte_op ? rdata_live :
		{8'h00, mem_address_b[0] ? rdata_live[15:8] : rdata_live[7:0]};

	////////////////////
	// write back
	////////////////////
	always_comb
	begin
		unique case (mem_wb.control.wb_sel)
			lc3b_pkg::wb_alu: wb_data = mem_wb.alu_out;
			lc3b_pkg::wb_mem: wb_data = mem_wb.rdata;
			lc3b_pkg::wb_addr: wb_data = mem_wb.address;
			lc3b_pkg::wb_pc: wb_data = mem_wb.next_pc;
		endcase
	end

	always_comb
	begin
		if (wb_data[15])
			wb_cc = 3'b100;
		else if (wb_data == '0)
			wb_cc = 3'b010;
		else
			wb_cc = 3'b001;
	end

	assign wb_dest = mem_wb.ir[11:9];
	assign wb_load_reg = advance && mem_wb.valid && mem_wb.control.load_regfile;
	assign wb_load_cc = advance && mem_wb.valid && mem_wb.control.load_cc;

	always_ff @(posedge clk or negedge arst_n)
	begin
		// zero flag out of reset
		if (!arst_n)
			nzp <= 3'b010;
		else if (wb_load_cc)
			nzp <= wb_cc;
	end

	// branch resolves here, target was formed in execute
	assign flush = mem_wb.valid && (mem_wb.control.opcode == lc3b_pkg::op_br) &&
		|(mem_wb.ir[11:9] & nzp);

	assert property (@(posedge clk) disable iff (!arst_n) !(mem_read_b && mem_write_b));

endmodule : datapath

// ==== design/execute_unit.sv ====
module execute_unit
(
	input lc3b_pkg::lc3b_control control,
	input lc3b_pkg::lc3b_word next_pc,
	input lc3b_pkg::lc3b_word ir,
	input lc3b_pkg::lc3b_word sr1,
	input lc3b_pkg::lc3b_word sr2,
	output lc3b_pkg::lc3b_word alu_out,
	output lc3b_pkg::lc3b_word address
);

	lc3b_pkg::lc3b_word imm5;
	lc3b_pkg::lc3b_word operand_b;
	lc3b_pkg::lc3b_word offset;
	lc3b_pkg::lc3b_word scaled;
	lc3b_pkg::lc3b_word base;

	////////////////////
	// alu
	////////////////////
	assign imm5 = {{11{ir[4]}}, ir[4:0]};
	assign operand_b = control.sr2_is_imm ? imm5 : sr2;

	always_comb
	begin
		unique case (control.alu_op)
			lc3b_pkg::alu_add: alu_out = sr1 + operand_b;
			lc3b_pkg::alu_and: alu_out = sr1 & operand_b;
			lc3b_pkg::alu_not: alu_out = ~sr1;
			lc3b_pkg::alu_pass: alu_out = operand_b;
		endcase
	end

	////////////////////
	// address adder
	////////////////////
	assign offset = control.addr_offset_sel ? {{7{ir[8]}}, ir[8:0]} :
		{{10{ir[5]}}, ir[5:0]};

	// word accesses count in words, byte accesses in bytes
	assign scaled = control.byte_op ? offset : {offset[14:0], 1'b0};
	assign base = control.addr_base_pc ? next_pc : sr1;
	assign address = base + scaled;

endmodule : execute_unit

// ==== design/lc3b_core.sv ====
module lc3b_core
(
	input logic clk,
	input logic arst_n,
	input logic mem_resp_a,
	input lc3b_pkg::lc3b_word mem_rdata_a,
	output logic mem_read_a,
	output lc3b_pkg::lc3b_word mem_address_a,
	input logic mem_resp_b,
	input lc3b_pkg::lc3b_word mem_rdata_b,
	output logic mem_read_b,
	output logic mem_write_b,
	output lc3b_pkg::lc3b_word mem_address_b,
	output lc3b_pkg::lc3b_word mem_wdata_b,
	output logic [1:0] mem_wmask_b
);

	lc3b_pkg::lc3b_word de_ir, reg_a, reg_b, wb_data;
	lc3b_pkg::lc3b_control de_control;
	lc3b_pkg::lc3b_reg src_a, src_b, wb_dest;
	logic wb_load_reg;

	datapath datapath
	(
		.clk,
		.arst_n,
		.mem_resp_a,
		.mem_rdata_a,
		.mem_read_a,
		.mem_address_a,
		.mem_resp_b,
		.mem_rdata_b,
		.mem_read_b,
		.mem_write_b,
		.mem_address_b,
		.mem_wdata_b,
		.mem_wmask_b,
		.de_ir,
		.de_control,
		.src_a,
		.src_b,
		.reg_a,
		.reg_b,
		.wb_load_reg,
		.wb_dest,
		.wb_data
	);

	control_rom control_rom
	(
		.ir(de_ir),
		.control(de_control)
	);

	regfile regfile
	(
		.clk,
		.arst_n,
		.load(wb_load_reg),
		.dest(wb_dest),
		.in(wb_data),
		.src_a,
		.src_b,
		.reg_a,
		.reg_b
	);

endmodule : lc3b_core

// ==== design/lc3b_pkg.sv ====
package lc3b_pkg;

	////////////////////
	// widths
	////////////////////
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// only the opcodes this core executes
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_ldi = 4'b1010,
		op_sti = 4'b1011,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} alu_op_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_addr,
		wb_pc
	} wb_sel_t;

	typedef struct packed {
		lc3b_opcode opcode;
		alu_op_t alu_op;
		logic sr2_is_imm;
		logic sr2_from_dest;
		// 0 picks offset6, 1 picks offset9
		logic addr_offset_sel;
		logic addr_base_pc;
		logic byte_op;
		logic read_memory;
		logic write_memory;
		logic indirect;
		logic load_regfile;
		logic load_cc;
		wb_sel_t wb_sel;
	} lc3b_control;

	////////////////////
	// pipeline stages
	////////////////////
	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_word ir;
		lc3b_word next_pc;
		lc3b_word sr1;
		lc3b_word sr2;
	} de_ex_t;

	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_word ir;
		lc3b_word next_pc;
		lc3b_word alu_out;
		lc3b_word address;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_word ir;
		lc3b_word next_pc;
		lc3b_word alu_out;
		lc3b_word address;
		lc3b_word rdata;
	} mem_wb_t;

	localparam lc3b_word reset_pc = 16'h0000;
	// BR with nzp = 000, never taken
	localparam lc3b_word nop_word = 16'h0000;

endpackage : lc3b_pkg

// ==== design/regfile.sv ====
module regfile
(
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_pkg::lc3b_reg dest,
	input lc3b_pkg::lc3b_word in,
	input lc3b_pkg::lc3b_reg src_a,
	input lc3b_pkg::lc3b_reg src_b,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);

	lc3b_pkg::lc3b_word regs [8];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (load)
		begin
			regs[dest] <= in;
		end
	end

	// no bypass, decode sees a write the cycle after
	assign reg_a = regs[src_a];
	assign reg_b = regs[src_b];

endmodule : regfile

// ==== design/stall_logic.sv ====
module stall_logic
(
	input logic clk,
	input logic arst_n,
	input logic advance,
	input logic read,
	input logic write,
	input logic indirect,
	input logic resp,
	output logic use_pointer,
	output logic hold_first,
	output logic access_done,
	output logic strobe_mask
);

	typedef enum logic [1:0] {
		s_idle,
		s_pointer,
		s_final
	} stall_state_t;

	stall_state_t state;
	stall_state_t next;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= s_idle;
		else
			state <= next;
	end

	always_comb
	begin
		next = state;
		unique case (state)
			s_idle:
				if ((read || write) && resp)
				begin
					if (indirect)
						next = s_pointer;
					else if (!advance)
						next = s_final;
				end
			s_pointer:
				if (resp)
					next = advance ? s_idle : s_final;
			s_final:
				if (advance)
					next = s_idle;
			default:
				next = s_idle;
		endcase
	end

	// second access of ldi/sti goes to the fetched pointer
	assign use_pointer = (state == s_pointer);
	assign hold_first = resp && (state != s_final);
	// s_final waits for fetch with the strobes dropped
	assign strobe_mask = (state != s_final);
	assign access_done = (state == s_final) ||
		(resp && ((state == s_pointer) || (state == s_idle && !indirect)));

	// memory stage always starts clean after the pipeline moves
	assert property (@(posedge clk) disable iff (!arst_n) advance |=> state == s_idle);

endmodule : stall_logic

// ==== sim.f ====
design/lc3b_pkg.sv
design/control_rom.sv
design/regfile.sv
design/execute_unit.sv
design/stall_logic.sv
design/datapath.sv
design/lc3b_core.sv
testbench/tb_memory.sv
testbench/tb_lc3b_core.sv

// ==== testbench/tb_lc3b_core.sv ====
module tb_lc3b_core;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		lc3b_pkg::lc3b_word addr;
		lc3b_pkg::lc3b_word data;
		logic [1:0] mask;
	} write_t;

	typedef struct packed {
		lc3b_pkg::lc3b_word addr;
		lc3b_pkg::lc3b_word value;
	} init_t;

	localparam int num_tests = 4;

	logic clk;
	logic arst_n;
	logic mem_resp_a, mem_read_a, mem_resp_b, mem_read_b, mem_write_b;
	logic [1:0] mem_wmask_b;
	lc3b_pkg::lc3b_word mem_rdata_a, mem_address_a, mem_rdata_b;
	lc3b_pkg::lc3b_word mem_address_b, mem_wdata_b;

	string test_name [num_tests];
	lc3b_pkg::lc3b_word image [num_tests][20];
	int image_len [num_tests];
	init_t data_init [num_tests][3];
	int init_count [num_tests];
	write_t expected [num_tests][5];
	int write_count [num_tests];

	write_t seen [$];
	int cycles;
	int cycle_limit;

	lc3b_core UUT
	(
		.clk(clk),
		.arst_n(arst_n),
		.mem_resp_a(mem_resp_a),
		.mem_rdata_a(mem_rdata_a),
		.mem_read_a(mem_read_a),
		.mem_address_a(mem_address_a),
		.mem_resp_b(mem_resp_b),
		.mem_rdata_b(mem_rdata_b),
		.mem_read_b(mem_read_b),
		.mem_write_b(mem_write_b),
		.mem_address_b(mem_address_b),
		.mem_wdata_b(mem_wdata_b),
		.mem_wmask_b(mem_wmask_b)
	);

	tb_memory memory
	(
		.clk(clk),
		.arst_n(arst_n),
		.read_a(mem_read_a),
		.address_a(mem_address_a),
		.resp_a(mem_resp_a),
		.rdata_a(mem_rdata_a),
		.read_b(mem_read_b),
		.write_b(mem_write_b),
		.address_b(mem_address_b),
		.wdata_b(mem_wdata_b),
		.wmask_b(mem_wmask_b),
		.resp_b(mem_resp_b),
		.rdata_b(mem_rdata_b)
	);

	always #10 clk = ~clk;

	// a write counts once, on its response
	always @(posedge clk)
	begin
		if (arst_n && mem_write_b && mem_resp_b)
			seen.push_back({mem_address_b, mem_wdata_b, mem_wmask_b});
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the programs did not finish within %0d cycles", cycle_limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic check_value(input string test, input string what,
		input lc3b_pkg::lc3b_word expected_value, input lc3b_pkg::lc3b_word actual);
		if (actual !== expected_value)
		begin
			$display("mismatch %s %s: expected %h actual %h", test, what, expected_value, actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	////////////////////
	// program table
	////////////////////
	// r6 = 0x0100 from lea, stores and loads go through it
	task automatic build_table();
		test_name[0] = "alu";
		image[0] = '{16'hEC7F, 16'h1227, 16'h143D, 16'h963F, 16'h0000,
			16'h0000, 16'h1842, 16'h5AC1, 16'h5EAE, 16'h7780,
			16'h7981, 16'h7B82, 16'h7F83, 16'h933F, 16'h0000,
			16'h0000, 16'h0000, 16'h7384, 16'h0FFF, 16'h0000};
		image_len[0] = 19;
		data_init[0] = '{32'h0, 32'h0, 32'h0};
		init_count[0] = 0;
		expected[0] = '{{16'h0100, 16'hFFFF, 2'b11}, {16'h0102, 16'h0004, 2'b11},
			{16'h0104, 16'h0007, 2'b11}, {16'h0106, 16'h000C, 2'b11},
			{16'h0108, 16'hFFFB, 2'b11}};
		write_count[0] = 5;

		// bytes 0x4e and 0xb7 copied to odd and even lanes
		test_name[1] = "byte";
		image[1] = '{16'hEC7F, 16'h0000, 16'h0000, 16'h0000, 16'h2380,
			16'h2581, 16'h0000, 16'h0000, 16'h3383, 16'h3584,
			16'h7583, 16'h7384, 16'h0FFF, 16'h0000, 16'h0000,
			16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		image_len[1] = 13;
		data_init[1] = '{32'h0100_B74E, 32'h0, 32'h0};
		init_count[1] = 1;
		expected[1] = '{{16'h0103, 16'h4E4E, 2'b10}, {16'h0104, 16'hB7B7, 2'b01},
			{16'h0106, 16'h00B7, 2'b11}, {16'h0108, 16'h004E, 2'b11}, 34'h0};
		write_count[1] = 4;

		test_name[2] = "indirect";
		image[2] = '{16'hEC7F, 16'h0000, 16'h0000, 16'h0000, 16'hA380,
			16'h1429, 16'h0000, 16'h0000, 16'h7382, 16'hB581,
			16'hA781, 16'h0000, 16'h0000, 16'h0000, 16'h7783,
			16'h0FFF, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
		image_len[2] = 16;
		data_init[2] = '{32'h0100_0120, 32'h0102_0130, 32'h0120_1234};
		init_count[2] = 3;
		expected[2] = '{{16'h0104, 16'h1234, 2'b11}, {16'h0130, 16'h0009, 2'b11},
			{16'h0106, 16'h0009, 2'b11}, 34'h0, 34'h0};
		write_count[2] = 3;

		// stores at 0x108 and 0x10a sit on skipped paths
		test_name[3] = "branch";
		image[3] = '{16'hEC7F, 16'h0000, 16'h0000, 16'h0000, 16'h6380,
			16'h0801, 16'h7D84, 16'h0401, 16'h1425, 16'h0201,
			16'h7D85, 16'h6781, 16'h0A01, 16'h7382, 16'h0401,
			16'h7D84, 16'h7583, 16'h0FFF, 16'h0000, 16'h0000};
		image_len[3] = 18;
		data_init[3] = '{32'h0100_8000, 32'h0102_0000, 32'h0};
		init_count[3] = 2;
		expected[3] = '{{16'h0104, 16'h8000, 2'b11}, {16'h0106, 16'h0005, 2'b11},
			34'h0, 34'h0, 34'h0};
		write_count[3] = 2;
	endtask

	task automatic run_program(input int t);
		write_t got;
		@(negedge clk);
		arst_n = 1'b0;
		memory.fill();
		for (int i = 0; i < 20; i++)
		begin
			memory.write_word(16'(2 * i), image[t][i]);
		end
		for (int i = 0; i < init_count[t]; i++)
		begin
			memory.write_word(data_init[t][i].addr, data_init[t][i].value);
		end
		repeat (4) @(negedge clk);
		seen.delete();
		arst_n = 1'b1;

		// fetch starts on the first clock out of reset
		@(negedge clk);
		check_value(test_name[t], "first fetch strobe", 16'h1, {15'h0, mem_read_a});
		check_value(test_name[t], "first fetch address", lc3b_pkg::reset_pc, mem_address_a);
		check_value(test_name[t], "data strobes at first fetch", 16'h0,
			{14'h0, mem_read_b, mem_write_b});

		for (int k = 0; k < write_count[t]; k++)
		begin
			while (seen.size() == 0)
				@(negedge clk);
			got = seen.pop_front();
			check_value(test_name[t], "write address", expected[t][k].addr, got.addr);
			check_value(test_name[t], "write data", expected[t][k].data, got.data);
			check_value(test_name[t], "write mask", {14'h0, expected[t][k].mask},
				{14'h0, got.mask});
		end

		// the program now spins on its last branch, no more stores may come
		repeat (60) @(negedge clk);
		check_value(test_name[t], "extra writes", 16'h0, 16'(seen.size()));
	endtask

	initial
	begin
		int total;
		void'($urandom(32'h0915_6d03));
		clk = 1'b0;
		arst_n = 1'b0;
		cycles = 0;
		build_table();
		total = 0;
		for (int t = 0; t < num_tests; t++)
		begin
			total += image_len[t];
		end
		cycle_limit = total * 40 + 200;

		for (int t = 0; t < num_tests; t++)
		begin
			run_program(t);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule : tb_lc3b_core

// ==== testbench/tb_memory.sv ====
module tb_memory
(
	input logic clk,
	input logic arst_n,
	input logic read_a,
	input lc3b_pkg::lc3b_word address_a,
	output logic resp_a,
	output lc3b_pkg::lc3b_word rdata_a,
	input logic read_b,
	input logic write_b,
	input lc3b_pkg::lc3b_word address_b,
	input lc3b_pkg::lc3b_word wdata_b,
	input logic [1:0] wmask_b,
	output logic resp_b,
	output lc3b_pkg::lc3b_word rdata_b
);

	timeunit 1ns;
	timeprecision 1ps;

	// 256 words, byte addresses 0 to 0x1ff
	lc3b_pkg::lc3b_word words [256];
	int wait_a;
	int wait_b;

	initial
	begin
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = '0;
		rdata_b = '0;
	end

	task automatic fill();
		for (int i = 0; i < 256; i++)
		begin
			words[i] = {8'(i) ^ 8'h5a, 8'(i)};
		end
	endtask

	task automatic write_word(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word value);
		words[addr[8:1]] = value;
	endtask

	////////////////////
	// response timing
	////////////////////
	// outputs change on the falling edge, the core samples them on the rising one
	always @(negedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			resp_a <= 1'b0;
			resp_b <= 1'b0;
			wait_a <= 0;
			wait_b <= 0;
		end
		else
		begin
			// a pulse lasts one cycle, the next request starts after it
			if (resp_a)
				resp_a <= 1'b0;
			else if (read_a)
			begin
				if (wait_a == 0)
				begin
					resp_a <= 1'b1;
					rdata_a <= words[address_a[8:1]];
					wait_a <= $urandom % 4;
				end
				else
					wait_a <= wait_a - 1;
			end

			if (resp_b)
				resp_b <= 1'b0;
			else if (read_b || write_b)
			begin
				if (wait_b == 0)
				begin
					resp_b <= 1'b1;
					rdata_b <= words[address_b[8:1]];
					if (write_b && wmask_b[0])
						words[address_b[8:1]][7:0] = wdata_b[7:0];
					if (write_b && wmask_b[1])
						words[address_b[8:1]][15:8] = wdata_b[15:8];
					wait_b <= $urandom % 4;
				end
				else
					wait_b <= wait_b - 1;
			end
		end
	end

endmodule : tb_memory
